// ==== logic/tlb_pkg.sv ====
package tlb_pkg;

    // plain vector types
    typedef logic [31:0] word_t;
    typedef logic [18:0] vpn2_t;
    typedef logic [19:0] vpn_t;
    typedef logic [7:0]  asid_t;
    typedef logic [19:0] pfn_t;
    typedef logic [2:0]  cache_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [73:0] tlb_entry_t;

    // entry layout, msb first: vpn2 asid g | pfn0 v0 d0 c0 | pfn1 v1 d1 c1
    localparam int ent_c1_bit   = 0;
    localparam int ent_d1_bit   = 1;
    localparam int ent_v1_bit   = 2;
    localparam int ent_pfn1_lsb = 3;
    localparam int ent_c0_bit   = 23;
    localparam int ent_d0_bit   = 24;
    localparam int ent_v0_bit   = 25;
    localparam int ent_pfn0_lsb = 26;
    localparam int ent_g_bit    = 46;
    localparam int ent_asid_lsb = 47;
    localparam int ent_vpn2_lsb = 55;

    // cp0 register numbers kept here
    localparam reg_addr_t reg_index    = 5'd0;
    localparam reg_addr_t reg_random   = 5'd1;
    localparam reg_addr_t reg_entrylo0 = 5'd2;
    localparam reg_addr_t reg_entrylo1 = 5'd3;
    localparam reg_addr_t reg_wired    = 5'd6;
    localparam reg_addr_t reg_entryhi  = 5'd10;

    // entrylo fields
    localparam int lo_g_bit   = 0;
    localparam int lo_v_bit   = 1;
    localparam int lo_d_bit   = 2;
    localparam int lo_c_lsb   = 3;
    localparam int lo_pfn_lsb = 6;

    // entryhi and index fields
    localparam int hi_asid_lsb = 0;
    localparam int hi_vpn2_lsb = 13;
    localparam int index_p_bit = 31;

    // writable bits on move-to
    localparam word_t entrylo_mask = 32'h03ff_ffff;
    localparam word_t entryhi_mask = 32'hffff_e0ff;

endpackage

// ==== logic/tlb_match.sv ====
`timescale 1ns/10ps

module tlb_match #(
    parameter int nr_entries = 8
) (
    input  tlb_pkg::tlb_entry_t           entries [nr_entries],
    input  tlb_pkg::asid_t                asid,
    input  tlb_pkg::vpn2_t                vpn2,
    output logic                          hit,
    output logic [$clog2(nr_entries)-1:0] hit_index
);
    import tlb_pkg::*;

    localparam int idx_w = $clog2(nr_entries);

    logic [nr_entries-1:0] match;

    // all entries compared at once
    always_comb begin
        for (int i = 0; i < nr_entries; i++) begin
            match[i] = (entries[i][ent_vpn2_lsb +: $bits(vpn2_t)] == vpn2) &&
                       (entries[i][ent_g_bit] ||
                        entries[i][ent_asid_lsb +: $bits(asid_t)] == asid);
        end
    end

    // or of matching slot numbers, only meaningful for a single hit
    always_comb begin
        hit_index = '0;
        for (int i = 0; i < nr_entries; i++) begin
            if (match[i]) begin
                hit_index = hit_index | idx_w'(i);
            end
        end
    end

    assign hit = |match;

endmodule

// ==== logic/tlb_array.sv ====
`timescale 1ns/10ps

module tlb_array #(
    parameter int nr_entries = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wr_en,
    input  logic [$clog2(nr_entries)-1:0] wr_index,
    input  tlb_pkg::tlb_entry_t           wr_entry,
    input  logic [$clog2(nr_entries)-1:0] rd_index,
    output tlb_pkg::tlb_entry_t           rd_entry,
    input  tlb_pkg::vpn2_t                cur_vpn2,
    input  tlb_pkg::asid_t                cur_asid,
    output logic                          probe_hit,
    output logic [$clog2(nr_entries)-1:0] probe_index,
    input  tlb_pkg::vpn_t                 itlb_vpn,
    output logic                          itlb_found,
    output tlb_pkg::pfn_t                 itlb_pfn,
    output logic                          itlb_valid,
    output logic                          itlb_dirty,
    output logic                          itlb_cached,
    input  tlb_pkg::vpn_t                 dtlb_vpn,
    output logic                          dtlb_found,
    output tlb_pkg::pfn_t                 dtlb_pfn,
    output logic                          dtlb_valid,
    output logic                          dtlb_dirty,
    output logic                          dtlb_cached
);
    import tlb_pkg::*;

    localparam int idx_w = $clog2(nr_entries);

    tlb_entry_t       entries [nr_entries];

    // port 0 is fetch, port 1 is data
    vpn_t             port_vpn    [2];
    logic             port_hit    [2];
    logic [idx_w-1:0] port_index  [2];
    pfn_t             port_pfn    [2];
    logic             port_valid  [2];
    logic             port_dirty  [2];
    logic             port_cached [2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < nr_entries; i++) begin
                entries[i] <= '0;
            end
        end else if (wr_en) begin
            entries[wr_index] <= wr_entry;
        end
    end

    assign rd_entry = entries[rd_index];

    // probe uses the current entryhi
    tlb_match #(.nr_entries(nr_entries)) probe_match (
        .entries   (entries),
        .asid      (cur_asid),
        .vpn2      (cur_vpn2),
        .hit       (probe_hit),
        .hit_index (probe_index)
    );

    assign port_vpn[0] = itlb_vpn;
    assign port_vpn[1] = dtlb_vpn;

    for (genvar p = 0; p < 2; p++) begin : g_port
        tlb_entry_t hit_entry;
        logic       odd;

        tlb_match #(.nr_entries(nr_entries)) port_match (
            .entries   (entries),
            .asid      (cur_asid),
            .vpn2      (port_vpn[p][$bits(vpn_t)-1:1]),
            .hit       (port_hit[p]),
            .hit_index (port_index[p])
        );

        // va bit 12 picks the odd page
        assign odd       = port_vpn[p][0];
        assign hit_entry = entries[port_index[p]];

        assign port_pfn[p]    = odd ? hit_entry[ent_pfn1_lsb +: $bits(pfn_t)]
                                    : hit_entry[ent_pfn0_lsb +: $bits(pfn_t)];
        assign port_valid[p]  = odd ? hit_entry[ent_v1_bit] : hit_entry[ent_v0_bit];
        assign port_dirty[p]  = odd ? hit_entry[ent_d1_bit] : hit_entry[ent_d0_bit];
        assign port_cached[p] = odd ? hit_entry[ent_c1_bit] : hit_entry[ent_c0_bit];
    end

    assign itlb_found  = port_hit[0];
    assign itlb_pfn    = port_pfn[0];
    assign itlb_valid  = port_valid[0];
    assign itlb_dirty  = port_dirty[0];
    assign itlb_cached = port_cached[0];

    assign dtlb_found  = port_hit[1];
    assign dtlb_pfn    = port_pfn[1];
    assign dtlb_valid  = port_valid[1];
    assign dtlb_dirty  = port_dirty[1];
    assign dtlb_cached = port_cached[1];

endmodule

// ==== logic/tlb_regs.sv ====
`timescale 1ns/10ps

module tlb_regs #(
    parameter int nr_entries = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          stall,
    input  logic                          mtc0_en,
    input  logic                          tlbwi,
    input  logic                          tlbwr,
    input  logic                          tlbp,
    input  logic                          tlbr,
    input  tlb_pkg::reg_addr_t            reg_addr,
    input  tlb_pkg::word_t                wdata,
    output tlb_pkg::word_t                rdata,
    output logic                          wr_en,
    output logic [$clog2(nr_entries)-1:0] wr_index,
    output tlb_pkg::tlb_entry_t           wr_entry,
    output logic [$clog2(nr_entries)-1:0] rd_index,
    output tlb_pkg::vpn2_t                cur_vpn2,
    output tlb_pkg::asid_t                cur_asid,
    input  tlb_pkg::tlb_entry_t           rd_entry,
    input  logic                          probe_hit,
    input  logic [$clog2(nr_entries)-1:0] probe_index
);
    import tlb_pkg::*;

    localparam int idx_w = $clog2(nr_entries);
    localparam logic [idx_w-1:0] top_index = idx_w'(nr_entries - 1);

    logic             index_p;
    logic [idx_w-1:0] index_val;
    logic [idx_w-1:0] random_q;
    logic [idx_w-1:0] wired_q;
    word_t            entrylo0_q;
    word_t            entrylo1_q;
    word_t            entryhi_q;

    logic   do_mtc0;
    logic   do_write;
    logic   do_probe;
    logic   do_read;
    cache_t c_even;
    cache_t c_odd;

    // strobe priority: mtc0, tlbwi, tlbwr, tlbp, tlbr
    assign do_mtc0  = !stall && mtc0_en;
    assign do_write = !stall && !mtc0_en && (tlbwi || tlbwr);
    assign do_probe = !stall && !mtc0_en && !tlbwi && !tlbwr && tlbp;
    assign do_read  = !stall && !mtc0_en && !tlbwi && !tlbwr && !tlbp && tlbr;

    assign wr_en    = do_write;
    assign wr_index = tlbwi ? index_val : random_q;
    assign rd_index = index_val;
    assign cur_vpn2 = entryhi_q[hi_vpn2_lsb +: $bits(vpn2_t)];
    assign cur_asid = entryhi_q[hi_asid_lsb +: $bits(asid_t)];

    // pack entryhi and both entrylo into one entry
    always_comb begin
        wr_entry = '0;
        wr_entry[ent_vpn2_lsb +: $bits(vpn2_t)] = cur_vpn2;
        wr_entry[ent_asid_lsb +: $bits(asid_t)] = cur_asid;
        wr_entry[ent_g_bit]    = entrylo0_q[lo_g_bit] & entrylo1_q[lo_g_bit];
        wr_entry[ent_pfn0_lsb +: $bits(pfn_t)] = entrylo0_q[lo_pfn_lsb +: $bits(pfn_t)];
        wr_entry[ent_v0_bit]   = entrylo0_q[lo_v_bit];
        wr_entry[ent_d0_bit]   = entrylo0_q[lo_d_bit];
        wr_entry[ent_c0_bit]   = entrylo0_q[lo_c_lsb];
        wr_entry[ent_pfn1_lsb +: $bits(pfn_t)] = entrylo1_q[lo_pfn_lsb +: $bits(pfn_t)];
        wr_entry[ent_v1_bit]   = entrylo1_q[lo_v_bit];
        wr_entry[ent_d1_bit]   = entrylo1_q[lo_d_bit];
        wr_entry[ent_c1_bit]   = entrylo1_q[lo_c_lsb];
    end

    // only the low cache bit is stored
    assign c_even = {2'b01, rd_entry[ent_c0_bit]};
    assign c_odd  = {2'b01, rd_entry[ent_c1_bit]};

    always_comb begin
        rdata = '0;
        case (reg_addr)
            reg_index: begin
                rdata = word_t'(index_val);
                rdata[index_p_bit] = index_p;
            end
            reg_random:   rdata = word_t'(random_q);
            reg_entrylo0: rdata = entrylo0_q;
            reg_entrylo1: rdata = entrylo1_q;
            reg_wired:    rdata = word_t'(wired_q);
            reg_entryhi:  rdata = entryhi_q;
            default:      rdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            index_p    <= 1'b0;
            index_val  <= '0;
            wired_q    <= '0;
            entrylo0_q <= '0;
            entrylo1_q <= '0;
            entryhi_q  <= '0;
        end else if (do_mtc0) begin
            case (reg_addr)
                reg_index: begin
                    index_p   <= 1'b0;
                    index_val <= wdata[idx_w-1:0];
                end
                reg_entrylo0: entrylo0_q <= wdata & entrylo_mask;
                reg_entrylo1: entrylo1_q <= wdata & entrylo_mask;
                reg_wired:    wired_q    <= wdata[idx_w-1:0];
                reg_entryhi:  entryhi_q  <= wdata & entryhi_mask;
                default: ;
            endcase
        end else if (do_probe) begin
            // a miss keeps the old index bits
            index_p <= !probe_hit;
            if (probe_hit) begin
                index_val <= probe_index;
            end
        end else if (do_read) begin
            entrylo0_q <= {6'b0, rd_entry[ent_pfn0_lsb +: $bits(pfn_t)], c_even,
                           rd_entry[ent_d0_bit], rd_entry[ent_v0_bit], rd_entry[ent_g_bit]};
            entrylo1_q <= {6'b0, rd_entry[ent_pfn1_lsb +: $bits(pfn_t)], c_odd,
                           rd_entry[ent_d1_bit], rd_entry[ent_v1_bit], rd_entry[ent_g_bit]};
            entryhi_q  <= {rd_entry[ent_vpn2_lsb +: $bits(vpn2_t)], 5'b0,
                           rd_entry[ent_asid_lsb +: $bits(asid_t)]};
        end
    end

    // random keeps counting through stalls
    always_ff @(posedge clk) begin
        if (rst) begin
            random_q <= top_index;
        end else if (do_mtc0 && reg_addr == reg_wired) begin
            random_q <= top_index;
        end else if (random_q == wired_q) begin
            random_q <= top_index;
        end else begin
            random_q <= random_q - 1'b1;
        end
    end

endmodule

// ==== logic/cp0_tlb.sv ====
`timescale 1ns/10ps

module cp0_tlb #(
    parameter int nr_entries = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               stall,
    input  logic               mtc0_en,
    input  logic               tlbwi,
    input  logic               tlbwr,
    input  logic               tlbp,
    input  logic               tlbr,
    input  tlb_pkg::reg_addr_t reg_addr,
    input  tlb_pkg::word_t     wdata,
    output tlb_pkg::word_t     rdata,
    // instruction fetch lookup
    input  tlb_pkg::vpn_t      itlb_vpn,
    output logic               itlb_found,
    output tlb_pkg::pfn_t      itlb_pfn,
    output logic               itlb_valid,
    output logic               itlb_dirty,
    output logic               itlb_cached,
    // data lookup
    input  tlb_pkg::vpn_t      dtlb_vpn,
    output logic               dtlb_found,
    output tlb_pkg::pfn_t      dtlb_pfn,
    output logic               dtlb_valid,
    output logic               dtlb_dirty,
    output logic               dtlb_cached
);
    import tlb_pkg::*;

    localparam int idx_w = $clog2(nr_entries);

    logic             wr_en;
    logic [idx_w-1:0] wr_index;
    tlb_entry_t       wr_entry;
    logic [idx_w-1:0] rd_index;
    tlb_entry_t       rd_entry;
    vpn2_t            cur_vpn2;
    asid_t            cur_asid;
    logic             probe_hit;
    logic [idx_w-1:0] probe_index;

    tlb_regs #(.nr_entries(nr_entries)) regs_inst (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .mtc0_en     (mtc0_en),
        .tlbwi       (tlbwi),
        .tlbwr       (tlbwr),
        .tlbp        (tlbp),
        .tlbr        (tlbr),
        .reg_addr    (reg_addr),
        .wdata       (wdata),
        .rdata       (rdata),
        .wr_en       (wr_en),
        .wr_index    (wr_index),
        .wr_entry    (wr_entry),
        .rd_index    (rd_index),
        .cur_vpn2    (cur_vpn2),
        .cur_asid    (cur_asid),
        .rd_entry    (rd_entry),
        .probe_hit   (probe_hit),
        .probe_index (probe_index)
    );

    tlb_array #(.nr_entries(nr_entries)) array_inst (
        .clk         (clk),
        .rst         (rst),
        .wr_en       (wr_en),
        .wr_index    (wr_index),
        .wr_entry    (wr_entry),
        .rd_index    (rd_index),
        .rd_entry    (rd_entry),
        .cur_vpn2    (cur_vpn2),
        .cur_asid    (cur_asid),
        .probe_hit   (probe_hit),
        .probe_index (probe_index),
        .itlb_vpn    (itlb_vpn),
        .itlb_found  (itlb_found),
        .itlb_pfn    (itlb_pfn),
        .itlb_valid  (itlb_valid),
        .itlb_dirty  (itlb_dirty),
        .itlb_cached (itlb_cached),
        .dtlb_vpn    (dtlb_vpn),
        .dtlb_found  (dtlb_found),
        .dtlb_pfn    (dtlb_pfn),
        .dtlb_valid  (dtlb_valid),
        .dtlb_dirty  (dtlb_dirty),
        .dtlb_cached (dtlb_cached)
    );

endmodule

// ==== bench/cp0_tlb_vectors.svh ====
`ifndef cp0_tlb_vectors_svh
`define cp0_tlb_vectors_svh

// columns: op, stall, register number or vpn, write data, expected, compare mask
// lookup results pack as {found, pfn, valid, dirty, cached} in bits 23..0
task automatic load_vectors();
    // reset state
    add_row(op_read,   0, 0,  32'h0, 32'h0, all_ones);
    add_row(op_read,   0, 2,  32'h0, 32'h0, all_ones);
    add_row(op_read,   0, 3,  32'h0, 32'h0, all_ones);
    add_row(op_read,   0, 10, 32'h0, 32'h0, all_ones);
    add_row(op_read,   0, 6,  32'h0, 32'h0, all_ones);
    // random counts down from 7 once per row after reset
    add_row(op_read,   0, 1,  32'h0, 32'h0000_0001, all_ones);
    // move-to masking
    add_row(op_write,  0, 2,  all_ones, 32'h0, 32'h0);
    add_row(op_read,   0, 2,  32'h0, 32'h03ff_ffff, all_ones);
    add_row(op_write,  0, 3,  all_ones, 32'h0, 32'h0);
    add_row(op_read,   0, 3,  32'h0, 32'h03ff_ffff, all_ones);
    add_row(op_write,  0, 10, all_ones, 32'h0, 32'h0);
    add_row(op_read,   0, 10, 32'h0, 32'hffff_e0ff, all_ones);
    add_row(op_write,  0, 0,  all_ones, 32'h0, 32'h0);
    add_row(op_read,   0, 0,  32'h0, 32'h0000_0007, all_ones);
    add_row(op_write,  0, 6,  all_ones, 32'h0, 32'h0);
    add_row(op_read,   0, 6,  32'h0, 32'h0000_0007, all_ones);
    add_row(op_write,  0, 4,  all_ones, 32'h0, 32'h0);
    add_row(op_read,   0, 4,  32'h0, 32'h0, all_ones);
    add_row(op_write,  0, 6,  32'h0, 32'h0, 32'h0);
    // slot 2, asid 5, even G set and odd G clear so the pair is not global
    add_row(op_write,  0, 10, 32'h0080_0005, 32'h0, 32'h0);
    add_row(op_write,  0, 2,  32'h0048_d15f, 32'h0, 32'h0);
    add_row(op_write,  0, 3,  32'h002a_f352, 32'h0, 32'h0);
    add_row(op_write,  0, 0,  32'h2, 32'h0, 32'h0);
    add_row(op_tlbwi,  0, 0,  32'h0, 32'h0, 32'h0);
    add_row(op_lookup, 0, 32'h00800, 32'h0, 32'h0089_1a2f, hit_mask);
    add_row(op_lookup, 0, 32'h00801, 32'h0, 32'h0085_5e6c, hit_mask);
    add_row(op_write,  0, 10, 32'h0080_0006, 32'h0, 32'h0);
    add_row(op_lookup, 0, 32'h00800, 32'h0, 32'h0, miss_mask);
    // slot 3, global pair
    add_row(op_write,  0, 10, 32'h0100_0007, 32'h0, 32'h0);
    add_row(op_write,  0, 2,  32'h0000_401b, 32'h0, 32'h0);
    add_row(op_write,  0, 3,  32'h0000_802f, 32'h0, 32'h0);
    add_row(op_write,  0, 0,  32'h3, 32'h0, 32'h0);
    add_row(op_tlbwi,  0, 0,  32'h0, 32'h0, 32'h0);
    add_row(op_write,  0, 10, 32'h0000_0009, 32'h0, 32'h0);
    add_row(op_lookup, 0, 32'h01000, 32'h0, 32'h0080_0805, hit_mask);
    add_row(op_lookup, 0, 32'h01001, 32'h0, 32'h0080_1007, hit_mask);
    // probe hit, then probe miss keeping index bits
    add_row(op_write,  0, 10, 32'h0080_0005, 32'h0, 32'h0);
    add_row(op_write,  0, 0,  32'h0, 32'h0, 32'h0);
    add_row(op_tlbp,   0, 0,  32'h0, 32'h0, 32'h0);
    add_row(op_read,   0, 0,  32'h0, 32'h0000_0002, all_ones);
    add_row(op_write,  0, 10, 32'h00a0_0005, 32'h0, 32'h0);
    add_row(op_tlbp,   0, 0,  32'h0, 32'h0, 32'h0);
    add_row(op_read,   0, 0,  32'h0, 32'h8000_0002, all_ones);
    // read back, c returns as 01 above the stored bit
    add_row(op_write,  0, 0,  32'h3, 32'h0, 32'h0);
    add_row(op_tlbr,   0, 0,  32'h0, 32'h0, 32'h0);
    add_row(op_read,   0, 10, 32'h0, 32'h0100_0007, all_ones);
    add_row(op_read,   0, 2,  32'h0, 32'h0000_401b, all_ones);
    add_row(op_read,   0, 3,  32'h0, 32'h0000_801f, all_ones);
    add_row(op_write,  0, 0,  32'h2, 32'h0, 32'h0);
    add_row(op_tlbr,   0, 0,  32'h0, 32'h0, 32'h0);
    add_row(op_read,   0, 2,  32'h0, 32'h0048_d15e, all_ones);
    // random write above wired 5
    add_row(op_write,  0, 6,  32'h5, 32'h0, 32'h0);
    add_row(op_write,  0, 10, 32'h0200_0005, 32'h0, 32'h0);
    add_row(op_write,  0, 2,  32'h0000_c01e, 32'h0, 32'h0);
    add_row(op_write,  0, 3,  32'h0001_0010, 32'h0, 32'h0);
    add_row(op_tlbwr,  0, 0,  32'h0, 32'h0, 32'h0);
    add_row(op_tlbp,   0, 0,  32'h0, 32'h0, 32'h0);
    add_row(op_range,  0, 0,  32'h0, 32'h0, 32'h0);
    add_row(op_lookup, 0, 32'h02000, 32'h0, 32'h0080_1807, hit_mask);
    add_row(op_lookup, 0, 32'h00800, 32'h0, 32'h0089_1a2f, hit_mask);
    add_row(op_lookup, 0, 32'h01001, 32'h0, 32'h0080_1007, hit_mask);
    // stalled instructions leave no trace
    add_row(op_write,  1, 10, 32'h00a0_0005, 32'h0, 32'h0);
    add_row(op_read,   0, 10, 32'h0, 32'h0200_0005, all_ones);
    add_row(op_write,  0, 10, 32'h0300_0005, 32'h0, 32'h0);
    add_row(op_write,  0, 0,  32'h4, 32'h0, 32'h0);
    add_row(op_tlbwi,  1, 0,  32'h0, 32'h0, 32'h0);
    add_row(op_lookup, 0, 32'h03000, 32'h0, 32'h0, miss_mask);
    add_row(op_tlbp,   1, 0,  32'h0, 32'h0, 32'h0);
    add_row(op_read,   0, 0,  32'h0, 32'h0000_0004, all_ones);
endtask

`endif

// ==== bench/cp0_tlb_tb.sv ====
`timescale 1ns/10ps

module cp0_tlb_tb;

    localparam int nr_entries = 8;
    localparam int clk_half   = 4;

    // row kinds of the stimulus table
    localparam int op_write  = 0;
    localparam int op_read   = 1;
    localparam int op_tlbwi  = 2;
    localparam int op_tlbwr  = 3;
    localparam int op_tlbp   = 4;
    localparam int op_tlbr   = 5;
    localparam int op_lookup = 6;
    localparam int op_range  = 7;

    localparam logic [31:0] all_ones  = 32'hffff_ffff;
    localparam logic [31:0] hit_mask  = 32'h00ff_ffff;
    localparam logic [31:0] miss_mask = 32'h0080_0000;
    localparam logic [31:0] wired_nr  = 32'd6;

    logic        clk;
    logic        rst;
    logic        stall;
    logic        mtc0_en;
    logic        tlbwi;
    logic        tlbwr;
    logic        tlbp;
    logic        tlbr;
    logic [4:0]  reg_addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [19:0] itlb_vpn;
    logic        itlb_found;
    logic [19:0] itlb_pfn;
    logic        itlb_valid;
    logic        itlb_dirty;
    logic        itlb_cached;
    logic [19:0] dtlb_vpn;
    logic        dtlb_found;
    logic [19:0] dtlb_pfn;
    logic        dtlb_valid;
    logic        dtlb_dirty;
    logic        dtlb_cached;

    // table columns, one entry per row
    int          q_op[$];
    int          q_stall[$];
    logic [31:0] q_addr[$];
    logic [31:0] q_data[$];
    logic [31:0] q_exp[$];
    logic [31:0] q_mask[$];

    // reference state for the random write checks
    int          model_wired;

    cp0_tlb #(.nr_entries(nr_entries)) cp0_tlb_inst (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .mtc0_en     (mtc0_en),
        .tlbwi       (tlbwi),
        .tlbwr       (tlbwr),
        .tlbp        (tlbp),
        .tlbr        (tlbr),
        .reg_addr    (reg_addr),
        .wdata       (wdata),
        .rdata       (rdata),
        .itlb_vpn    (itlb_vpn),
        .itlb_found  (itlb_found),
        .itlb_pfn    (itlb_pfn),
        .itlb_valid  (itlb_valid),
        .itlb_dirty  (itlb_dirty),
        .itlb_cached (itlb_cached),
        .dtlb_vpn    (dtlb_vpn),
        .dtlb_found  (dtlb_found),
        .dtlb_pfn    (dtlb_pfn),
        .dtlb_valid  (dtlb_valid),
        .dtlb_dirty  (dtlb_dirty),
        .dtlb_cached (dtlb_cached)
    );

    always #(clk_half) clk = ~clk;

    task automatic add_row(int op, int stl, logic [31:0] addr, logic [31:0] data,
                           logic [31:0] exp, logic [31:0] mask);
        q_op.push_back(op);
        q_stall.push_back(stl);
        q_addr.push_back(addr);
        q_data.push_back(data);
        q_exp.push_back(exp);
        q_mask.push_back(mask);
    endtask

    `include "cp0_tlb_vectors.svh"

    task automatic stop_on_error(string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] got);
        stop_on_error($sformatf("Mismatch at %0t: %s expected %h got %h",
                                $time, name, exp, got));
    endtask

    // count falling edges
    task automatic wait_falls(int count);
        for (int n = 0; n < count; n++) begin
            @(negedge clk);
        end
    endtask

    task automatic apply_row(int op, int stl, logic [31:0] addr, logic [31:0] data);
        stall    = (stl != 0);
        mtc0_en  = (op == op_write);
        tlbwi    = (op == op_tlbwi);
        tlbwr    = (op == op_tlbwr);
        tlbp     = (op == op_tlbp);
        tlbr     = (op == op_tlbr);
        reg_addr = addr[4:0];
        wdata    = data;
        if (op == op_lookup) begin
            itlb_vpn = addr[19:0];
            dtlb_vpn = addr[19:0];
        end
        // wired keeps only the index bits
        if (op == op_write && stl == 0 && addr == wired_nr) begin
            model_wired = int'(data & (nr_entries - 1));
        end
    endtask

    task automatic check_row(int op, logic [31:0] addr, logic [31:0] exp, logic [31:0] mask);
        logic [31:0] itlb_got;
        logic [31:0] dtlb_got;
        itlb_got = {8'b0, itlb_found, itlb_pfn, itlb_valid, itlb_dirty, itlb_cached};
        dtlb_got = {8'b0, dtlb_found, dtlb_pfn, dtlb_valid, dtlb_dirty, dtlb_cached};
        if (op == op_read) begin
            assert ((rdata & mask) == (exp & mask))
                else report_mismatch("rdata", exp & mask, rdata);
        end else if (op == op_lookup) begin
            assert ((itlb_got & mask) == (exp & mask))
                else report_mismatch("itlb_found/pfn/valid/dirty/cached", exp & mask,
                                     itlb_got & mask);
            assert ((dtlb_got & mask) == (exp & mask))
                else report_mismatch("dtlb_found/pfn/valid/dirty/cached", exp & mask,
                                     dtlb_got & mask);
        end else if (op == op_range) begin
            // random slots lie between wired and the top entry
            assert (rdata[31] == 1'b0 && int'(rdata) >= model_wired &&
                    int'(rdata) < nr_entries)
                else stop_on_error($sformatf(
                    "at %0t register %0d read %h, which is outside %0d to %0d or has P set",
                    $time, addr[4:0], rdata, model_wired, nr_entries - 1));
        end
    endtask

    initial begin
        int r;
        clk         = 1'b0;
        rst         = 1'b1;
        stall       = 1'b0;
        mtc0_en     = 1'b0;
        tlbwi       = 1'b0;
        tlbwr       = 1'b0;
        tlbp        = 1'b0;
        tlbr        = 1'b0;
        reg_addr    = '0;
        wdata       = '0;
        itlb_vpn    = '0;
        dtlb_vpn    = '0;
        model_wired = 0;
        load_vectors();
        wait_falls(4);
        rst = 1'b0;
        // one row per cycle, results seen after the following edge
        for (r = 0; r < q_op.size(); r++) begin
            apply_row(q_op[r], q_stall[r], q_addr[r], q_data[r]);
            wait_falls(1);
            check_row(q_op[r], q_addr[r], q_exp[r], q_mask[r]);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+bench
logic/tlb_pkg.sv
logic/tlb_match.sv
logic/tlb_array.sv
logic/tlb_regs.sv
logic/cp0_tlb.sv
bench/cp0_tlb_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cp0_tlb testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/10ps \
    --top-module cp0_tlb_tb \
    -f project.f \
    -o cp0_tlb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status" >&2
    exit "$status"
fi

./obj_dir/cp0_tlb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status" >&2
    exit "$status"
fi

exit 0
